// File: common/vm1_pkg.sv
package vm1_pkg;

    // ====================
    // widths
    // ====================
    localparam int WORD_W    = 16;
    localparam int NUM_REGS  = 8;
    localparam int REG_IDX_W = 3;

    typedef logic [WORD_W-1:0] word_t;

    // fetch address after reset
    localparam word_t START_PC = 16'o1000;

    // bus address source
    localparam logic [1:0] ADDR_SEL_PC  = 2'd0;
    localparam logic [1:0] ADDR_SEL_REG = 2'd1;
    localparam logic [1:0] ADDR_SEL_ADR = 2'd2;

    // ====================
    // types
    // ====================
    // OP_STOP covers HALT and everything outside the subset
    typedef enum logic [4:0] {
        OP_MOV,
        OP_CMP,
        OP_ADD,
        OP_SUB,
        OP_BIC,
        OP_BIS,
        OP_CLR,
        OP_COM,
        OP_INC,
        OP_DEC,
        OP_NEG,
        OP_TST,
        OP_BR,
        OP_BNE,
        OP_BEQ,
        OP_BPL,
        OP_BMI,
        OP_STOP
    } opcode_e;

    typedef enum logic [2:0] {
        BOOT,
        FETCH,
        DECODE,
        SRC_READ,
        DST_READ,
        EXECUTE,
        WRITEBACK,
        STOPPED
    } state_e;

    typedef enum logic [3:0] {
        ALU_PASS,
        ALU_ADD,
        ALU_SUB,
        ALU_BIC,
        ALU_BIS,
        ALU_CLR,
        ALU_COM,
        ALU_INC,
        ALU_DEC,
        ALU_NEG
    } alu_op_e;

    typedef enum logic [1:0] {
        MODE_REG,
        MODE_DEFER,
        MODE_AUTOINC
    } mode_e;

endpackage

// File: datapath/alu.sv
`timescale 1ns/1ns

module alu
    import vm1_pkg::*;
(
    input  word_t    a_i,
    input  word_t    b_i,
    input  alu_op_e  op_i,
    output word_t    result_o,
    output logic     n_o,
    output logic     z_o,
    output logic     v_o,
    output logic     c_o,
    output logic     keep_c_o
);

    localparam int MSB = WORD_W - 1;

    logic [WORD_W:0] sum;

    // a is the destination operand, b the source
    always_comb begin
        sum      = '0;
        result_o = b_i;
        v_o      = 1'b0;
        c_o      = 1'b0;
        keep_c_o = 1'b0;
        case (op_i)
            ALU_ADD: begin
                sum      = {1'b0, a_i} + {1'b0, b_i};
                result_o = sum[MSB:0];
                c_o      = sum[WORD_W];
                v_o      = (a_i[MSB] == b_i[MSB]) && (result_o[MSB] != a_i[MSB]);
            end
            ALU_SUB: begin
                // C is the borrow
                sum      = {1'b0, a_i} - {1'b0, b_i};
                result_o = sum[MSB:0];
                c_o      = sum[WORD_W];
                v_o      = (a_i[MSB] != b_i[MSB]) && (result_o[MSB] != a_i[MSB]);
            end
            ALU_BIC: begin
                result_o = a_i & ~b_i;
                keep_c_o = 1'b1;
            end
            ALU_BIS: begin
                result_o = a_i | b_i;
                keep_c_o = 1'b1;
            end
            ALU_CLR: begin
                result_o = '0;
            end
            ALU_COM: begin
                result_o = ~a_i;
                c_o      = 1'b1;
            end
            ALU_INC: begin
                result_o = a_i + 16'd1;
                v_o      = (a_i == 16'o077777);
                keep_c_o = 1'b1;
            end
            ALU_DEC: begin
                result_o = a_i - 16'd1;
                v_o      = (a_i == 16'o100000);
                keep_c_o = 1'b1;
            end
            ALU_NEG: begin
                result_o = -a_i;
                v_o      = (result_o == 16'o100000);
                c_o      = (result_o != '0);
            end
            default: begin
                keep_c_o = 1'b1;
            end
        endcase
    end

    assign n_o = result_o[MSB];
    assign z_o = (result_o == '0);

endmodule

// File: datapath/datapath.sv
`timescale 1ns/1ns

module datapath
    import vm1_pkg::*;
#(
    parameter word_t START_ADDR = START_PC
)
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic [1:0]            addr_sel_i,
    input  logic                  src_latch_i,
    input  logic                  dst_latch_i,
    input  logic                  ir_load_i,
    input  logic                  autoinc_i,
    input  logic                  reg_sel_dst_i,
    input  alu_op_e               alu_op_i,
    input  logic                  cc_load_i,
    input  logic                  reg_we_i,
    input  logic                  branch_i,
    input  logic [REG_IDX_W-1:0]  src_reg_i,
    input  logic [REG_IDX_W-1:0]  dst_reg_i,
    input  logic [7:0]            branch_offset_i,
    input  word_t                 rdata_i,
    output word_t                 instr_o,
    output word_t                 addr_o,
    output word_t                 wdata_o,
    output logic [3:0]            cc_o
);

    word_t                 regs [NUM_REGS];
    word_t                 ir_q;
    word_t                 src_q;
    word_t                 dst_q;
    word_t                 adr_q;
    logic [3:0]            cc_q;
    logic [REG_IDX_W-1:0]  sel_reg;
    logic [REG_IDX_W-1:0]  other_reg;
    logic                  reading;
    word_t                 branch_disp;
    word_t                 alu_result;
    logic                  n;
    logic                  z;
    logic                  v;
    logic                  c;
    logic                  keep_c;

    // sel_reg addresses memory operands, other_reg feeds the DST latch
    assign sel_reg     = reg_sel_dst_i ? dst_reg_i : src_reg_i;
    assign other_reg   = reg_sel_dst_i ? src_reg_i : dst_reg_i;
    assign reading     = (addr_sel_i == ADDR_SEL_REG);
    assign branch_disp = {{7{branch_offset_i[7]}}, branch_offset_i, 1'b0};

    always_comb begin
        case (addr_sel_i)
            ADDR_SEL_REG: addr_o = regs[sel_reg];
            ADDR_SEL_ADR: addr_o = adr_q;
            default:      addr_o = regs[NUM_REGS-1];
        endcase
    end

    // ====================
    // register file, R7 is the PC
    // ====================
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            regs[NUM_REGS-1] <= START_ADDR;
        end else if (ir_load_i) begin
            regs[NUM_REGS-1] <= regs[NUM_REGS-1] + 16'd2;
        end else if (branch_i) begin
            regs[NUM_REGS-1] <= regs[NUM_REGS-1] + branch_disp;
        end else if (autoinc_i) begin
            regs[sel_reg] <= regs[sel_reg] + 16'd2;
        end else if (reg_we_i) begin
            regs[dst_reg_i] <= alu_result;
        end
    end

    // operand latches take bus data while reading, else a register
    always_ff @(posedge clk) begin
        if (ir_load_i) begin
            ir_q <= rdata_i;
        end
        if (src_latch_i) begin
            src_q <= reading ? rdata_i : regs[sel_reg];
        end
        if (dst_latch_i) begin
            dst_q <= reading ? rdata_i : regs[other_reg];
        end
        // keep the destination address for writeback
        if (dst_latch_i && reading) begin
            adr_q <= regs[sel_reg];
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            cc_q <= 4'b0000;
        end else if (cc_load_i) begin
            cc_q <= {n, z, v, keep_c ? cc_q[0] : c};
        end
    end

    alu alu_inst (
        .a_i      (dst_q),
        .b_i      (src_q),
        .op_i     (alu_op_i),
        .result_o (alu_result),
        .n_o      (n),
        .z_o      (z),
        .v_o      (v),
        .c_o      (c),
        .keep_c_o (keep_c)
    );

    assign instr_o = ir_q;
    assign wdata_o = alu_result;
    assign cc_o    = cc_q;

endmodule

// File: files.f
common/vm1_pkg.sv
logic/instr_decoder.sv
sequencer/sequencer.sv
datapath/alu.sv
datapath/datapath.sv
logic/bus_unit.sv
logic/vm1_core.sv
verif/vm1_core_assertions.sv
verif/tb_vm1_core.sv

// File: logic/bus_unit.sv
`timescale 1ns/1ns

module bus_unit
    import vm1_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    input  logic   rd_req_i,
    input  logic   wr_req_i,
    input  logic   ifetch_i,
    input  word_t  addr_i,
    input  word_t  wdata_i,
    input  word_t  bus_rdata_i,
    input  logic   bus_ready_i,
    output logic   bus_rd_o,
    output logic   bus_wr_o,
    output logic   bus_ifetch_o,
    output word_t  bus_addr_o,
    output word_t  bus_wdata_o,
    output word_t  rdata_o,
    output logic   done_o
);

    logic  busy;
    logic  rd_q;
    logic  wr_q;
    logic  ifetch_q;
    word_t addr_q;
    word_t wdata_q;

    // a request not answered in its first cycle is held here
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            busy     <= 1'b0;
            rd_q     <= 1'b0;
            wr_q     <= 1'b0;
            ifetch_q <= 1'b0;
        end else if (!busy) begin
            busy     <= (rd_req_i || wr_req_i) && !bus_ready_i;
            rd_q     <= rd_req_i;
            wr_q     <= wr_req_i;
            ifetch_q <= ifetch_i;
        end else if (bus_ready_i) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy) begin
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
        end
    end

    assign bus_rd_o     = busy ? rd_q : rd_req_i;
    assign bus_wr_o     = busy ? wr_q : wr_req_i;
    assign bus_ifetch_o = busy ? ifetch_q : ifetch_i;
    assign bus_addr_o   = busy ? addr_q : addr_i;
    assign bus_wdata_o  = busy ? wdata_q : wdata_i;

    // no added latency, done and data on the ready cycle
    assign done_o  = bus_ready_i && (bus_rd_o || bus_wr_o);
    assign rdata_o = bus_rdata_i;

endmodule

// File: logic/instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder
    import vm1_pkg::*;
(
    input  word_t                 instr_i,
    output opcode_e               opcode_o,
    output mode_e                 src_mode_o,
    output mode_e                 dst_mode_o,
    output logic [REG_IDX_W-1:0]  src_reg_o,
    output logic [REG_IDX_W-1:0]  dst_reg_o,
    output logic [7:0]            branch_offset_o
);

    logic src_ok;
    logic dst_ok;

    // only modes 0, 1 and 2
    assign src_ok = (instr_i[11:9] <= 3'd2);
    assign dst_ok = (instr_i[5:3] <= 3'd2);

    assign src_reg_o       = instr_i[8:6];
    assign dst_reg_o       = instr_i[2:0];
    assign branch_offset_o = instr_i[7:0];
    assign src_mode_o      = src_ok ? mode_e'(instr_i[10:9]) : MODE_REG;
    assign dst_mode_o      = dst_ok ? mode_e'(instr_i[4:3]) : MODE_REG;

    always_comb begin
        // double operand, word forms only
        case (instr_i[15:12])
            4'h1:    opcode_o = OP_MOV;
            4'h2:    opcode_o = OP_CMP;
            4'h4:    opcode_o = OP_BIC;
            4'h5:    opcode_o = OP_BIS;
            4'h6:    opcode_o = OP_ADD;
            4'he:    opcode_o = OP_SUB;
            default: opcode_o = OP_STOP;
        endcase
        if (!(src_ok && dst_ok)) begin
            opcode_o = OP_STOP;
        end

        // single operand group 0050DD..0057DD
        if (instr_i[15:9] == 7'b000_0101 && dst_ok) begin
            case (instr_i[8:6])
                3'o0:    opcode_o = OP_CLR;
                3'o1:    opcode_o = OP_COM;
                3'o2:    opcode_o = OP_INC;
                3'o3:    opcode_o = OP_DEC;
                3'o4:    opcode_o = OP_NEG;
                3'o7:    opcode_o = OP_TST;
                default: opcode_o = OP_STOP;
            endcase
        end

        // branches, offset in the low byte
        case (instr_i[15:8])
            8'h01:   opcode_o = OP_BR;
            8'h02:   opcode_o = OP_BNE;
            8'h03:   opcode_o = OP_BEQ;
            8'h80:   opcode_o = OP_BPL;
            8'h81:   opcode_o = OP_BMI;
            default: ;
        endcase
    end

endmodule

// File: logic/vm1_core.sv
`timescale 1ns/1ns

module vm1_core
    import vm1_pkg::*;
#(
    parameter word_t START_ADDR = START_PC
)
(
    input  logic   clk,
    input  logic   reset_n,
    output word_t  bus_addr_o,
    output word_t  bus_wdata_o,
    input  word_t  bus_rdata_i,
    output logic   bus_rd_o,
    output logic   bus_wr_o,
    output logic   bus_ifetch_o,
    input  logic   bus_ready_i,
    output logic   halted_o
);

    logic                  rd_req;
    logic                  wr_req;
    logic                  ifetch;
    logic [1:0]            addr_sel;
    logic                  src_latch;
    logic                  dst_latch;
    logic                  ir_load;
    logic                  autoinc;
    logic                  reg_sel_dst;
    alu_op_e               alu_op;
    logic                  cc_load;
    logic                  reg_we;
    logic                  branch;
    logic [3:0]            cc;
    logic                  bus_done;
    word_t                 rdata;
    word_t                 instr;
    word_t                 addr;
    word_t                 wdata;
    opcode_e               opcode;
    mode_e                 src_mode;
    mode_e                 dst_mode;
    logic [REG_IDX_W-1:0]  src_reg;
    logic [REG_IDX_W-1:0]  dst_reg;
    logic [7:0]            branch_offset;

    sequencer sequencer_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .opcode_i      (opcode),
        .src_mode_i    (src_mode),
        .dst_mode_i    (dst_mode),
        .cc_i          (cc),
        .bus_done_i    (bus_done),
        .bus_rd_req_o  (rd_req),
        .bus_wr_req_o  (wr_req),
        .ifetch_o      (ifetch),
        .addr_sel_o    (addr_sel),
        .src_latch_o   (src_latch),
        .dst_latch_o   (dst_latch),
        .ir_load_o     (ir_load),
        .autoinc_o     (autoinc),
        .reg_sel_dst_o (reg_sel_dst),
        .alu_op_o      (alu_op),
        .cc_load_o     (cc_load),
        .reg_we_o      (reg_we),
        .branch_o      (branch),
        .halted_o      (halted_o)
    );

    datapath #(
        .START_ADDR (START_ADDR)
    ) datapath_inst (
        .clk             (clk),
        .reset_n         (reset_n),
        .addr_sel_i      (addr_sel),
        .src_latch_i     (src_latch),
        .dst_latch_i     (dst_latch),
        .ir_load_i       (ir_load),
        .autoinc_i       (autoinc),
        .reg_sel_dst_i   (reg_sel_dst),
        .alu_op_i        (alu_op),
        .cc_load_i       (cc_load),
        .reg_we_i        (reg_we),
        .branch_i        (branch),
        .src_reg_i       (src_reg),
        .dst_reg_i       (dst_reg),
        .branch_offset_i (branch_offset),
        .rdata_i         (rdata),
        .instr_o         (instr),
        .addr_o          (addr),
        .wdata_o         (wdata),
        .cc_o            (cc)
    );

    instr_decoder instr_decoder_inst (
        .instr_i         (instr),
        .opcode_o        (opcode),
        .src_mode_o      (src_mode),
        .dst_mode_o      (dst_mode),
        .src_reg_o       (src_reg),
        .dst_reg_o       (dst_reg),
        .branch_offset_o (branch_offset)
    );

    bus_unit bus_unit_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .rd_req_i     (rd_req),
        .wr_req_i     (wr_req),
        .ifetch_i     (ifetch),
        .addr_i       (addr),
        .wdata_i      (wdata),
        .bus_rdata_i  (bus_rdata_i),
        .bus_ready_i  (bus_ready_i),
        .bus_rd_o     (bus_rd_o),
        .bus_wr_o     (bus_wr_o),
        .bus_ifetch_o (bus_ifetch_o),
        .bus_addr_o   (bus_addr_o),
        .bus_wdata_o  (bus_wdata_o),
        .rdata_o      (rdata),
        .done_o       (bus_done)
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the vm1_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_vm1_core -f files.f \
    -o sim_tb > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "Result: FAILED" sim.log && { echo "simulation failed"; exit 1; } || \
    grep -q "Result: PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }

// File: sequencer/sequencer.sv
`timescale 1ns/1ns

module sequencer
    import vm1_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  opcode_e     opcode_i,
    input  mode_e       src_mode_i,
    input  mode_e       dst_mode_i,
    input  logic [3:0]  cc_i,
    input  logic        bus_done_i,
    output logic        bus_rd_req_o,
    output logic        bus_wr_req_o,
    output logic        ifetch_o,
    output logic [1:0]  addr_sel_o,
    output logic        src_latch_o,
    output logic        dst_latch_o,
    output logic        ir_load_o,
    output logic        autoinc_o,
    output logic        reg_sel_dst_o,
    output alu_op_e     alu_op_o,
    output logic        cc_load_o,
    output logic        reg_we_o,
    output logic        branch_o,
    output logic        halted_o
);

    state_e state;
    state_e state_next;
    logic   is_dop;
    logic   flags_only;
    logic   taken;

    assign is_dop = opcode_i inside {OP_MOV, OP_CMP, OP_ADD, OP_SUB, OP_BIC, OP_BIS};

    // CMP and TST only set flags
    // their operands go to the other latch so the ALU sees src-dst and a plain pass
    assign flags_only = opcode_i inside {OP_CMP, OP_TST};

    // cc_i is {N, Z, V, C}
    always_comb begin
        case (opcode_i)
            OP_BR:   taken = 1'b1;
            OP_BNE:  taken = !cc_i[2];
            OP_BEQ:  taken = cc_i[2];
            OP_BPL:  taken = !cc_i[3];
            OP_BMI:  taken = cc_i[3];
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (opcode_i)
            OP_ADD:  alu_op_o = ALU_ADD;
            OP_SUB:  alu_op_o = ALU_SUB;
            OP_CMP:  alu_op_o = ALU_SUB;
            OP_BIC:  alu_op_o = ALU_BIC;
            OP_BIS:  alu_op_o = ALU_BIS;
            OP_CLR:  alu_op_o = ALU_CLR;
            OP_COM:  alu_op_o = ALU_COM;
            OP_INC:  alu_op_o = ALU_INC;
            OP_DEC:  alu_op_o = ALU_DEC;
            OP_NEG:  alu_op_o = ALU_NEG;
            default: alu_op_o = ALU_PASS;
        endcase
    end

    // ====================
    // state machine
    // ====================
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= BOOT;
        end else begin
            state <= state_next;
        end
    end

    assign halted_o = (state == STOPPED);

    always_comb begin
        state_next    = state;
        bus_rd_req_o  = 1'b0;
        bus_wr_req_o  = 1'b0;
        ifetch_o      = 1'b0;
        addr_sel_o    = ADDR_SEL_PC;
        src_latch_o   = 1'b0;
        dst_latch_o   = 1'b0;
        ir_load_o     = 1'b0;
        autoinc_o     = 1'b0;
        reg_sel_dst_o = 1'b0;
        cc_load_o     = 1'b0;
        reg_we_o      = 1'b0;
        branch_o      = 1'b0;

        case (state)
            BOOT: begin
                state_next = FETCH;
            end
            FETCH: begin
                bus_rd_req_o = 1'b1;
                ifetch_o     = 1'b1;
                if (bus_done_i) begin
                    ir_load_o  = 1'b1;
                    state_next = DECODE;
                end
            end
            DECODE: begin
                if (opcode_i == OP_STOP) begin
                    state_next = STOPPED;
                end else if (opcode_i inside {OP_BR, OP_BNE, OP_BEQ, OP_BPL, OP_BMI}) begin
                    branch_o   = taken;
                    state_next = FETCH;
                end else begin
                    // register operands are taken here
                    reg_sel_dst_o = flags_only;
                    if (is_dop && src_mode_i == MODE_REG) begin
                        src_latch_o = !flags_only;
                        dst_latch_o = flags_only;
                    end
                    if (dst_mode_i == MODE_REG) begin
                        src_latch_o = src_latch_o | flags_only;
                        dst_latch_o = dst_latch_o | !flags_only;
                    end
                    if (is_dop && src_mode_i != MODE_REG) begin
                        state_next = SRC_READ;
                    end else if (dst_mode_i != MODE_REG) begin
                        state_next = DST_READ;
                    end else begin
                        state_next = EXECUTE;
                    end
                end
            end
            SRC_READ: begin
                bus_rd_req_o = 1'b1;
                addr_sel_o   = ADDR_SEL_REG;
                if (bus_done_i) begin
                    src_latch_o = !flags_only;
                    dst_latch_o = flags_only;
                    autoinc_o   = (src_mode_i == MODE_AUTOINC);
                    state_next  = (dst_mode_i != MODE_REG) ? DST_READ : EXECUTE;
                end
            end
            DST_READ: begin
                bus_rd_req_o  = 1'b1;
                addr_sel_o    = ADDR_SEL_REG;
                reg_sel_dst_o = 1'b1;
                if (bus_done_i) begin
                    src_latch_o = flags_only;
                    dst_latch_o = !flags_only;
                    autoinc_o   = (dst_mode_i == MODE_AUTOINC);
                    state_next  = EXECUTE;
                end
            end
            EXECUTE: begin
                cc_load_o  = 1'b1;
                state_next = flags_only ? FETCH : WRITEBACK;
            end
            WRITEBACK: begin
                if (dst_mode_i == MODE_REG) begin
                    reg_we_o   = 1'b1;
                    state_next = FETCH;
                end else begin
                    // store to the address saved during DST_READ
                    bus_wr_req_o = 1'b1;
                    addr_sel_o   = ADDR_SEL_ADR;
                    if (bus_done_i) begin
                        state_next = FETCH;
                    end
                end
            end
            default: begin
                state_next = STOPPED;
            end
        endcase
    end

endmodule

// File: verif/tb_vm1_core.sv
`timescale 1ns/1ns

module tb_vm1_core
    import vm1_pkg::*;
();

    localparam word_t STORE_BASE     = 16'o4000;
    localparam int    MAX_INSTR      = 64;
    localparam int    TIMEOUT_CYCLES = 4 * MAX_INSTR * 8 + 200;
    localparam int    SETTLE_CYCLES  = 40;
    localparam int    NUM_TESTS      = 5;

    logic   clk = 1'b0;
    logic   reset_n;
    word_t  bus_addr_o;
    word_t  bus_wdata_o;
    word_t  bus_rdata_i = '0;
    logic   bus_rd_o;
    logic   bus_wr_o;
    logic   bus_ifetch_o;
    logic   bus_ready_i = 1'b0;
    logic   halted_o;

    word_t  mem [32768];
    word_t  written [word_t];
    word_t  exp_data [$];
    int     exp_test [$];
    int     test_errors [NUM_TESTS];
    int     test_stores [NUM_TESTS];
    int     test_expected [NUM_TESTS];
    string  test_names [NUM_TESTS] = '{"arithmetic stores", "dec/bne loop", "cmp/beq",
                                        "bpl/bmi", "halt"};
    integer seed = 32'h269c_833a;
    integer rnd;
    int     stall_run = 0;
    int     store_count = 0;
    int     extra_stores = 0;
    int     late_strobes = 0;
    word_t  pc;

    always #2 clk = ~clk;

    vm1_core vm1_core_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .bus_addr_o   (bus_addr_o),
        .bus_wdata_o  (bus_wdata_o),
        .bus_rdata_i  (bus_rdata_i),
        .bus_rd_o     (bus_rd_o),
        .bus_wr_o     (bus_wr_o),
        .bus_ifetch_o (bus_ifetch_o),
        .bus_ready_i  (bus_ready_i),
        .halted_o     (halted_o)
    );

    function automatic word_t fill_word(input word_t addr);
        return addr ^ {addr[7:0], addr[15:8]} ^ 16'h6c39;
    endfunction

    task automatic emit(input word_t w);
        mem[pc[15:1]] = w;
        pc = pc + 16'd2;
    endtask

    task automatic expect_store(input int test, input word_t value);
        exp_data.push_back(value);
        exp_test.push_back(test);
        test_expected[test]++;
    endtask

    task automatic record_store(input word_t addr, input word_t data);
        int idx;
        int t;
        idx = store_count;
        store_count++;
        written[addr] = data;
        if (idx >= exp_data.size()) begin
            $display("store %0d to %h is beyond the expected store sequence", idx, addr);
            extra_stores++;
            return;
        end
        t = exp_test[idx];
        test_stores[t]++;
        if (addr != STORE_BASE + word_t'(2 * idx)) begin
            $display("CHECK FAILED bus_addr_o store %0d expected %h got %h",
                     idx, STORE_BASE + word_t'(2 * idx), addr);
            test_errors[t]++;
        end
        if (data != exp_data[idx]) begin
            $display("CHECK FAILED bus_wdata_o store %0d expected %h got %h",
                     idx, exp_data[idx], data);
            test_errors[t]++;
        end
    endtask

    // program image and the stores it should make
    task automatic build_program();
        word_t r2;
        word_t r3;
        word_t r5;
        word_t sum;
        for (int i = 0; i < 32768; i++) begin
            mem[i] = fill_word(word_t'(i * 2));
        end
        pc = START_PC;
        r2 = 16'h1234;
        r3 = 16'h0f0f;
        r5 = 16'hff00;
        emit(16'o012701);
        emit(STORE_BASE);
        emit(16'o012702);
        emit(r2);
        emit(16'o012703);
        emit(r3);
        emit(16'o010221);
        expect_store(0, r2);
        emit(16'o060203);
        r3 = r3 + r2;
        emit(16'o010321);
        expect_store(0, r3);
        emit(16'o160203);
        r3 = r3 - r2;
        emit(16'o010321);
        expect_store(0, r3);
        emit(16'o040302);
        r2 = r2 & ~r3;
        emit(16'o010221);
        expect_store(0, r2);
        emit(16'o050302);
        r2 = r2 | r3;
        emit(16'o010221);
        expect_store(0, r2);
        emit(16'o005102);
        r2 = ~r2;
        emit(16'o010221);
        expect_store(0, r2);
        emit(16'o005403);
        r3 = -r3;
        emit(16'o010321);
        expect_store(0, r3);
        emit(16'o005203);
        r3 = r3 + 16'd1;
        emit(16'o010321);
        expect_store(0, r3);
        emit(16'o005302);
        r2 = r2 - 16'd1;
        emit(16'o010221);
        expect_store(0, r2);
        emit(16'o005021);
        expect_store(0, 16'h0000);
        // add into untouched memory, fill value plus R2
        sum = fill_word(STORE_BASE + word_t'(2 * exp_data.size())) + r2;
        emit(16'o060221);
        expect_store(0, sum);
        // BR over a HALT
        emit(16'o000401);
        emit(16'o000000);

        // count 5 down, one store per pass
        emit(16'o012704);
        emit(16'd5);
        emit(16'o010421);
        emit(16'o005304);
        emit(16'o001375);
        for (int k = 5; k > 0; k--) begin
            expect_store(1, word_t'(k));
        end

        emit(16'o020202);
        emit(16'o001402);
        emit(16'o012721);
        emit(16'hbeef);
        emit(16'o020203);
        emit(16'o001402);
        emit(16'o012721);
        emit(16'hcafe);
        if (r2 != r3) begin
            expect_store(2, 16'hcafe);
        end

        // negative value, then R4 which ends the loop at zero
        emit(16'o012705);
        emit(r5);
        emit(16'o005705);
        emit(16'o100002);
        emit(16'o012721);
        emit(16'h0a0a);
        // the store above sets N again, so test R5 before BMI
        emit(16'o005705);
        emit(16'o100402);
        emit(16'o012721);
        emit(16'h0b0b);
        if (r5[15]) begin
            expect_store(3, 16'h0a0a);
        end else begin
            expect_store(3, 16'h0b0b);
        end
        emit(16'o005704);
        emit(16'o100002);
        emit(16'o012721);
        emit(16'h0c0c);
        emit(16'o100402);
        emit(16'o012721);
        emit(16'h0d0d);
        expect_store(3, 16'h0d0d);
        emit(16'o000000);
    endtask

    // ====================
    // memory model, driven on the falling edge
    // ====================
    always @(negedge clk) begin
        if (halted_o && (bus_rd_o || bus_wr_o)) begin
            late_strobes++;
        end
        rnd = $random(seed);
        if (stall_run == 3 || rnd[1:0] != 2'b00) begin
            bus_ready_i = 1'b1;
            stall_run   = 0;
        end else begin
            bus_ready_i = 1'b0;
            stall_run   = stall_run + 1;
        end
        // a write completes at the next rising edge when ready is high now
        if (reset_n && bus_wr_o && bus_ready_i) begin
            record_store(bus_addr_o, bus_wdata_o);
        end
        if (written.exists(bus_addr_o)) begin
            bus_rdata_i = written[bus_addr_o];
        end else begin
            bus_rdata_i = mem[bus_addr_o[15:1]];
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout, core did not halt within %0d cycles", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int failed;
        int errs;
        int assert_errs;
        failed  = 0;
        reset_n = 1'b0;
        build_program();
        repeat (3) @(negedge clk);
        reset_n = 1'b1;
        while (!halted_o) @(negedge clk);
        repeat (SETTLE_CYCLES) @(negedge clk);

        for (int t = 0; t < NUM_TESTS - 1; t++) begin
            errs = test_errors[t];
            if (test_stores[t] != test_expected[t]) begin
                $display("%0s made %0d stores instead of %0d", test_names[t],
                         test_stores[t], test_expected[t]);
                errs++;
            end
            $display("test %0s: %0s", test_names[t], (errs == 0) ? "ok" : "failed");
            if (errs != 0) begin
                failed++;
            end
        end
        errs = late_strobes + extra_stores;
        $display("test %0s: %0s", test_names[NUM_TESTS-1], (errs == 0) ? "ok" : "failed");
        if (errs != 0) begin
            failed++;
        end
        assert_errs = vm1_core_inst.assertions_inst.error_count;
        $display("bus protocol assertions: %0d errors", assert_errs);
        if (assert_errs != 0) begin
            failed++;
        end

        $display("%0d checks run, %0d passed, %0d failed", NUM_TESTS + 1,
                 NUM_TESTS + 1 - failed, failed);
        if (failed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: verif/vm1_core_assertions.sv
`timescale 1ns/1ns

module vm1_core_assertions
    import vm1_pkg::*;
#(
    parameter word_t START_ADDR = START_PC
)
(
    input logic   clk,
    input logic   reset_n,
    input logic   bus_rd_i,
    input logic   bus_wr_i,
    input logic   bus_ifetch_i,
    input word_t  bus_addr_i,
    input word_t  bus_wdata_i,
    input logic   bus_ready_i,
    input logic   halted_i
);

    int error_count = 0;

    // ====================
    // reset and first fetch
    // ====================
    quiet_in_reset: assert property (@(posedge clk)
        !reset_n |-> !bus_rd_i && !bus_wr_i && !bus_ifetch_i && !halted_i)
        else begin
            $error("bus strobe or halted_o active in reset");
            error_count++;
        end

    // boot cycle right after reset is still quiet
    boot_quiet: assert property (@(posedge clk)
        $rose(reset_n) |-> !bus_rd_i && !bus_wr_i)
        else begin
            $error("bus strobe active in the boot cycle");
            error_count++;
        end

    first_fetch: assert property (@(posedge clk)
        $rose(reset_n) |=> bus_rd_i && bus_ifetch_i && bus_addr_i == START_ADDR)
        else begin
            $error("first request is not a fetch at the start address");
            error_count++;
        end

    // ====================
    // handshake under stalls
    // ====================
    read_held: assert property (@(posedge clk) disable iff (!reset_n)
        bus_rd_i && !bus_ready_i |=>
            bus_rd_i && $stable(bus_addr_i) && $stable(bus_ifetch_i))
        else begin
            $error("read request changed before ready");
            error_count++;
        end

    write_held: assert property (@(posedge clk) disable iff (!reset_n)
        bus_wr_i && !bus_ready_i |=>
            bus_wr_i && $stable(bus_addr_i) && $stable(bus_wdata_i))
        else begin
            $error("write request changed before ready");
            error_count++;
        end

    one_strobe: assert property (@(posedge clk) disable iff (!reset_n)
        !(bus_rd_i && bus_wr_i))
        else begin
            $error("read and write strobes high together");
            error_count++;
        end

    // halted core stays silent
    halt_sticky: assert property (@(posedge clk) disable iff (!reset_n)
        halted_i |=> halted_i && !bus_rd_i && !bus_wr_i)
        else begin
            $error("bus activity or halt drop after HALT");
            error_count++;
        end

endmodule

bind vm1_core vm1_core_assertions #(
    .START_ADDR (START_ADDR)
) assertions_inst (
    .clk          (clk),
    .reset_n      (reset_n),
    .bus_rd_i     (bus_rd_o),
    .bus_wr_i     (bus_wr_o),
    .bus_ifetch_i (bus_ifetch_o),
    .bus_addr_i   (bus_addr_o),
    .bus_wdata_i  (bus_wdata_o),
    .bus_ready_i  (bus_ready_i),
    .halted_i     (halted_o)
);
